// File: dnc_pkg.sv
////////////////////////////////////////
// DNC output stage shared definitions
// Data and size widths, their vector
// types and the sequencer states
////////////////////////////////////////

package dnc_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data element, full-width wrap-around arithmetic
  localparam int DNC_DATA_SIZE = 16;
  // Dimension size, valid range 1 to 255
  localparam int DNC_SIZE_SIZE = 8;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // K, r, nu, products, sums and y
  typedef logic [DNC_DATA_SIZE-1:0] data_t;

  // Y, R, W sizes and loop indices
  typedef logic [DNC_SIZE_SIZE-1:0] size_t;

  // Sequencer FSM
  typedef enum logic [1:0] {
    STARTER_STATE,
    STREAM_STATE,
    DONE_STATE
  } sequencer_state_t;

endpackage

// File: dnc_output_sequencer.sv
////////////////////////////////////////
// DNC output sequencer
// Latches Y, R, W on START, walks the
// y/i/k pair stream, counts nu strobes
////////////////////////////////////////

module dnc_output_sequencer (
  input  logic           CLK,
  input  logic           RST,
  input  logic           START,
  input  logic           K_IN_ENABLE,
  input  logic           NU_IN_ENABLE,
  input  dnc_pkg::size_t SIZE_Y_IN,
  input  dnc_pkg::size_t SIZE_R_IN,
  input  dnc_pkg::size_t SIZE_W_IN,
  output logic           pair_enable,
  output logic           pair_first,
  output logic           pair_last,
  output logic           nu_enable,
  output logic           READY
);

  import dnc_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  sequencer_state_t state;

  // Latched dimension sizes
  size_t size_y;
  size_t size_r;
  size_t size_w;

  // Loop indices, k innermost
  size_t k_cnt;
  size_t i_cnt;
  size_t y_cnt;
  size_t nu_cnt;

  // All Y*R*W pairs taken
  logic pairs_done;

  // Last index values
  size_t y_top;
  size_t r_top;
  size_t w_top;

  logic k_wrap;
  logic i_wrap;
  logic stream;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign y_top = size_y - 8'd1;
  assign r_top = size_r - 8'd1;
  assign w_top = size_w - 8'd1;

  assign k_wrap = (k_cnt == w_top);
  assign i_wrap = (i_cnt == r_top);
  assign stream = (state == STREAM_STATE);

  // Strobes only count while streaming
  assign pair_enable = K_IN_ENABLE & stream & ~pairs_done;
  assign nu_enable   = NU_IN_ENABLE & stream;

  // First and last pair of the current y
  assign pair_first = pair_enable & (i_cnt == '0) & (k_cnt == '0);
  assign pair_last  = pair_enable & i_wrap & k_wrap;

  // One-cycle done pulse
  assign READY = (state == DONE_STATE);

  // Operation sizes, captured at START
  always_ff @(posedge CLK) begin
    if (state == STARTER_STATE && START) begin
      size_y <= SIZE_Y_IN;
      size_r <= SIZE_R_IN;
      size_w <= SIZE_W_IN;
    end
  end

  ////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= STARTER_STATE;
      k_cnt      <= '0;
      i_cnt      <= '0;
      y_cnt      <= '0;
      nu_cnt     <= '0;
      pairs_done <= 1'b0;
    end else begin
      case (state)
        STARTER_STATE: begin
          if (START) begin
            k_cnt      <= '0;
            i_cnt      <= '0;
            y_cnt      <= '0;
            nu_cnt     <= '0;
            pairs_done <= 1'b0;
            state      <= STREAM_STATE;
          end
        end
        STREAM_STATE: begin
          // k, then i, then y
          if (pair_enable) begin
            if (k_wrap) begin
              k_cnt <= '0;
              if (i_wrap) begin
                i_cnt <= '0;
                y_cnt <= y_cnt + 8'd1;
                // Stop after the last y
                if (y_cnt == y_top) begin
                  pairs_done <= 1'b1;
                end
              end else begin
                i_cnt <= i_cnt + 8'd1;
              end
            end else begin
              k_cnt <= k_cnt + 8'd1;
            end
          end
          // Y-th nu strobe ends the operation
          if (nu_enable) begin
            nu_cnt <= nu_cnt + 8'd1;
            if (nu_cnt == y_top) begin
              state <= DONE_STATE;
            end
          end
        end
        DONE_STATE: begin
          state <= STARTER_STATE;
        end
        default: begin
          state <= STARTER_STATE;
        end
      endcase
    end
  end

endmodule

// File: dnc_dot_accumulator.sv
////////////////////////////////////////
// DNC dot accumulator
// Wrap-around K*r multiply-accumulate,
// one dot product per y
////////////////////////////////////////

module dnc_dot_accumulator (
  input  logic           CLK,
  input  logic           RST,
  input  logic           pair_enable,
  input  logic           pair_first,
  input  logic           pair_last,
  input  dnc_pkg::data_t K_IN,
  input  dnc_pkg::data_t R_IN,
  output logic           dot_enable,
  output dnc_pkg::data_t dot_sum
);

  import dnc_pkg::*;

  // Product truncated to data width
  data_t product;
  // Running sum over i and k
  data_t acc;
  // Sum including this pair
  data_t acc_next;

  assign product = data_t'(K_IN * R_IN);

  // First pair of a y restarts the sum
  assign acc_next = pair_first ? product : data_t'(acc + product);

  always_ff @(posedge CLK) begin
    if (pair_enable) begin
      acc <= acc_next;
    end
  end

  // Finished total sits in acc for the cycle after pair_last
  assign dot_sum = acc;

  // Result strobe one cycle after pair_last
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      dot_enable <= 1'b0;
    end else begin
      dot_enable <= pair_last;
    end
  end

endmodule

// File: dnc_bias_adder.sv
////////////////////////////////////////
// DNC bias adder
// Adds nu to the waiting dot product
// and issues y with its pulse
////////////////////////////////////////

module dnc_bias_adder (
  input  logic           CLK,
  input  logic           RST,
  input  logic           dot_enable,
  input  dnc_pkg::data_t dot_sum,
  input  logic           nu_enable,
  input  dnc_pkg::data_t NU_IN,
  output dnc_pkg::data_t Y_OUT,
  output logic           Y_OUT_ENABLE
);

  import dnc_pkg::*;

  // One-entry slot for the latest dot product
  data_t slot;
  // Slot value seen by the adder
  data_t dot_value;

  always_ff @(posedge CLK) begin
    if (dot_enable) begin
      slot <= dot_sum;
    end
  end

  // Bypass when nu lands in the same cycle as the dot product
  assign dot_value = dot_enable ? dot_sum : slot;

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      Y_OUT        <= '0;
      Y_OUT_ENABLE <= 1'b0;
    end else begin
      Y_OUT_ENABLE <= nu_enable;
      // Y_OUT holds between results
      if (nu_enable) begin
        Y_OUT <= data_t'(dot_value + NU_IN);
      end
    end
  end

endmodule

// File: dnc_output_vector.sv
////////////////////////////////////////
// DNC output vector
// y(y) = sum K(i,y,k)*r(i,k) + nu(y),
// sequencer, accumulator, bias adder
////////////////////////////////////////

module dnc_output_vector (
  // Global
  input  logic           CLK,
  input  logic           RST,

  // Control
  input  logic           START,
  output logic           READY,
  input  logic           K_IN_ENABLE,
  input  logic           NU_IN_ENABLE,
  output logic           Y_OUT_ENABLE,

  // Data
  input  dnc_pkg::size_t SIZE_Y_IN,
  input  dnc_pkg::size_t SIZE_R_IN,
  input  dnc_pkg::size_t SIZE_W_IN,
  input  dnc_pkg::data_t K_IN,
  input  dnc_pkg::data_t R_IN,
  input  dnc_pkg::data_t NU_IN,
  output dnc_pkg::data_t Y_OUT
);

  import dnc_pkg::*;

  ////////////////////////////////////////
  // Internal strobes
  ////////////////////////////////////////

  // Sequencer to accumulator
  logic pair_enable;
  logic pair_first;
  logic pair_last;

  // Sequencer to bias adder
  logic nu_enable;

  // Accumulator to bias adder
  logic  dot_enable;
  data_t dot_sum;

  // Index decode and nu count
  dnc_output_sequencer i_dnc_output_sequencer (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .K_IN_ENABLE  (K_IN_ENABLE),
    .NU_IN_ENABLE (NU_IN_ENABLE),
    .SIZE_Y_IN    (SIZE_Y_IN),
    .SIZE_R_IN    (SIZE_R_IN),
    .SIZE_W_IN    (SIZE_W_IN),
    .pair_enable  (pair_enable),
    .pair_first   (pair_first),
    .pair_last    (pair_last),
    .nu_enable    (nu_enable),
    .READY        (READY)
  );

  // K*r dot product per y
  dnc_dot_accumulator i_dnc_dot_accumulator (
    .CLK         (CLK),
    .RST         (RST),
    .pair_enable (pair_enable),
    .pair_first  (pair_first),
    .pair_last   (pair_last),
    .K_IN        (K_IN),
    .R_IN        (R_IN),
    .dot_enable  (dot_enable),
    .dot_sum     (dot_sum)
  );

  // Plus nu, out to Y_OUT
  dnc_bias_adder i_dnc_bias_adder (
    .CLK          (CLK),
    .RST          (RST),
    .dot_enable   (dot_enable),
    .dot_sum      (dot_sum),
    .nu_enable    (nu_enable),
    .NU_IN        (NU_IN),
    .Y_OUT        (Y_OUT),
    .Y_OUT_ENABLE (Y_OUT_ENABLE)
  );

endmodule

// File: dnc_output_vector_tb.sv
////////////////////////////////////////
// DNC output vector testbench
// Directed tests against a software
// model of y = sum K*r + nu
////////////////////////////////////////

module dnc_output_vector_tb;

  import dnc_pkg::*;

  logic  CLK = 1'b0;
  logic  RST, START, K_IN_ENABLE, NU_IN_ENABLE, READY, Y_OUT_ENABLE;
  size_t SIZE_Y_IN, SIZE_R_IN, SIZE_W_IN;
  data_t K_IN, R_IN, NU_IN, Y_OUT;

  // Operands by flat pair index (y*R+i)*W+k
  data_t k_mem[$];
  data_t r_mem[$];
  data_t nu_mem[$];
  int    nu_cyc[$];
  // Collected results with their cycle numbers
  data_t got_q[$];
  int    got_cyc[$];
  int    cyc = 0;
  int    ready_cnt = 0;
  int    ready_cyc = 0;
  int    errors = 0;
  int    checks = 0;
  logic [31:0] seed = 32'hd905_3a01;

  dnc_output_vector i_dnc_output_vector (.*);

  always #5 CLK = ~CLK;

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  // Outputs sampled before the edge updates them
  always @(posedge CLK) begin : collect_outputs
    if (Y_OUT_ENABLE) begin
      got_q.push_back(Y_OUT);
      got_cyc.push_back(cyc);
    end
    if (READY) begin
      ready_cnt++;
      ready_cyc = cyc;
    end
  end

  ////////////////////////////////////////
  // Model and helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // 0 small, 1 random, 2 near 16'hffff
  function automatic data_t operand(input int mode);
    logic [31:0] v;
    v = lcg_next();
    case (mode)
      0: return {12'h000, v[19:16]};
      1: return v[31:16];
      default: return 16'hffff - {12'h000, v[19:16]};
    endcase
  endfunction

  // Full sum first and one truncation at the end
  function automatic data_t model_y(input int y, input int nr, input int nw);
    logic [31:0] sum;
    sum = 32'(nu_mem[y]);
    for (int j = 0; j < nr * nw; j++) begin
      sum += 32'(k_mem[y * nr * nw + j]) * 32'(r_mem[y * nr * nw + j]);
    end
    return sum[15:0];
  endfunction

  function automatic logic op_done(input int n_out, input int n_ready);
    return (got_q.size() >= n_out) && (ready_cnt > n_ready);
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic fill_operands(input int ny, input int nr, input int nw, input int mode);
    k_mem.delete();
    r_mem.delete();
    nu_mem.delete();
    nu_cyc.delete();
    for (int j = 0; j < ny * nr * nw; j++) begin
      k_mem.push_back(operand(mode));
      r_mem.push_back(operand(mode));
    end
    for (int y = 0; y < ny; y++) begin
      nu_mem.push_back(operand(mode));
      nu_cyc.push_back(0);
    end
  endtask

  task automatic set_nu(input int y);
    NU_IN_ENABLE = 1'b1;
    NU_IN        = nu_mem[y];
    nu_cyc[y]    = cyc;
  endtask

  task automatic end_cycle();
    @(negedge CLK);
    K_IN_ENABLE  = 1'b0;
    NU_IN_ENABLE = 1'b0;
  endtask

  ////////////////////////////////////////
  // Operation driver
  ////////////////////////////////////////

  task automatic drive_op(input int ny, input int nr, input int nw,
                          input int gap_max, input bit overlap);
    int idx;
    int gap;
    idx = 0;
    START     = 1'b1;
    SIZE_Y_IN = size_t'(ny);
    SIZE_R_IN = size_t'(nr);
    SIZE_W_IN = size_t'(nw);
    @(negedge CLK);
    START = 1'b0;
    for (int y = 0; y < ny; y++) begin
      for (int j = 0; j < nr * nw; j++) begin
        gap = int'(lcg_next() >> 24) % (gap_max + 1);
        repeat (gap) @(negedge CLK);
        K_IN_ENABLE = 1'b1;
        K_IN        = k_mem[idx];
        R_IN        = r_mem[idx];
        idx++;
        // nu of the previous y on the pair before this y's last one
        if (overlap && y > 0 && j == nr * nw - 2) begin
          set_nu(y - 1);
        end
        end_cycle();
      end
      // Right behind the last pair in the dot_enable cycle
      if (!overlap) begin
        set_nu(y);
        end_cycle();
      end
    end
    if (overlap) begin
      repeat (gap_max) @(negedge CLK);
      set_nu(ny - 1);
      end_cycle();
    end
  endtask

  task automatic run_op(input int ny, input int nr, input int nw, input int mode,
                        input int gap_max, input bit overlap);
    int base_out;
    int base_ready;
    int t;
    fill_operands(ny, nr, nw, mode);
    base_out   = got_q.size();
    base_ready = ready_cnt;
    drive_op(ny, nr, nw, gap_max, overlap);
    t = 0;
    while (!op_done(base_out + ny, base_ready) && t < 100) begin
      @(negedge CLK);
      t++;
    end
    if (!op_done(base_out + ny, base_ready)) begin
      errors++;
      $display("Timeout: Y_OUT_ENABLE or READY missing after %0d cycles", t);
    end
    // Room for a stray extra pulse
    repeat (3) @(negedge CLK);
    check_flag("Y_OUT_ENABLE count ok", got_q.size() == base_out + ny, 1'b1);
    check_flag("READY count ok", ready_cnt == base_ready + 1, 1'b1);
    for (int y = 0; y < ny && base_out + y < got_q.size(); y++) begin
      check_data("Y_OUT", got_q[base_out + y], model_y(y, nr, nw));
      check_flag("Y_OUT_ENABLE one cycle after NU_IN_ENABLE",
                 got_cyc[base_out + y] == nu_cyc[y] + 1, 1'b1);
    end
    if (got_q.size() == base_out + ny) begin
      check_flag("READY with last Y_OUT_ENABLE",
                 ready_cyc == got_cyc[base_out + ny - 1], 1'b1);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset_values();
    check_flag("READY", READY, 1'b0);
    check_flag("Y_OUT_ENABLE", Y_OUT_ENABLE, 1'b0);
    check_data("Y_OUT", Y_OUT, 16'h0000);
  endtask

  // Strobes while idle and then two clean operations
  task automatic test_idle_then_repeat();
    int base_out;
    base_out     = got_q.size();
    K_IN_ENABLE  = 1'b1;
    NU_IN_ENABLE = 1'b1;
    repeat (3) @(negedge CLK);
    end_cycle();
    repeat (3) @(negedge CLK);
    check_flag("Y_OUT_ENABLE while idle", got_q.size() != base_out, 1'b0);
    run_op(2, 3, 1, 1, 1, 1'b1);
    run_op(3, 1, 2, 1, 0, 1'b0);
  endtask

  initial begin
    RST          = 1'b1;
    START        = 1'b0;
    K_IN_ENABLE  = 1'b0;
    NU_IN_ENABLE = 1'b0;
    SIZE_Y_IN    = '0;
    SIZE_R_IN    = '0;
    SIZE_W_IN    = '0;
    K_IN         = '0;
    R_IN         = '0;
    NU_IN        = '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    test_reset_values();
    run_op(1, 1, 1, 0, 0, 1'b0);
    run_op(4, 2, 3, 1, 0, 1'b0);
    run_op(3, 2, 2, 2, 0, 1'b0);
    run_op(3, 2, 3, 1, 3, 1'b1);
    test_idle_then_repeat();
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $display("%0d checks, %0d errors", checks, errors);
    $finish;
  end

endmodule

// File: dnc_output_vector.f
dnc_pkg.sv
dnc_output_sequencer.sv
dnc_dot_accumulator.sv
dnc_bias_adder.sv
dnc_output_vector.sv
dnc_output_vector_tb.sv

// File: Makefile
SIM        := verilator
TOP        := dnc_output_vector_tb
FILE_LIST  := dnc_output_vector.f
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
LOG        := sim.log
PASS_TEXT  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf obj_dir $(LOG)
